//--- rv_exec_config.svh
/* Execute pipeline configuration
 * Data path, instruction and register index widths
 */

`ifndef RV_EXEC_CONFIG_SVH
`define RV_EXEC_CONFIG_SVH

// Data path and PC width
`define XLEN 64

// Instruction width
`define ILEN 32

// Register index width
`define REG_ADDR_W 5

`endif

//--- rv_exec_pkg.sv
/* Execute pipeline types
 * Opcodes, ALU and branch encodings, and the items passed between stages
 */

`default_nettype none

`include "rv_exec_config.svh"

package rv_exec_pkg;

        //////////////////////////////////////////////////////////////////////
        // Encodings
        //////////////////////////////////////////////////////////////////////
        typedef enum logic [6:0] {
                OP_LUI    = 7'b0110111,
                OP_AUIPC  = 7'b0010111,
                OP_JAL    = 7'b1101111,
                OP_JALR   = 7'b1100111,
                OP_BRANCH = 7'b1100011,
                OP_IMM    = 7'b0010011,
                OP_REG    = 7'b0110011
        } opcode_e;

        typedef enum logic [3:0] {
                ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
                ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
        } alu_op_e;

        typedef enum logic [2:0] {  // Same as branch funct3
                BR_BEQ  = 3'b000,
                BR_BNE  = 3'b001,
                BR_BLT  = 3'b100,
                BR_BGE  = 3'b101,
                BR_BLTU = 3'b110,
                BR_BGEU = 3'b111
        } br_cond_e;

        typedef enum logic [1:0] {
                CTL_ALU,                // Write-back only
                CTL_BRANCH,             // Redirect only
                CTL_JUMP                // Link write-back and redirect
        } ctl_kind_e;

        //////////////////////////////////////////////////////////////////////
        // Stage items
        //////////////////////////////////////////////////////////////////////
        typedef struct packed {
                logic [`XLEN-1:0]       pc;
                logic [`ILEN-1:0]       inst;
                logic [`XLEN-1:0]       rs1_val;
                logic [`XLEN-1:0]       rs2_val;
        } exec_req_t;

        typedef struct packed {
                ctl_kind_e              kind;
                alu_op_e                alu_op;
                br_cond_e               br_cond;
                logic [`XLEN-1:0]       opnd_a;
                logic [`XLEN-1:0]       opnd_b;
                logic [`XLEN-1:0]       target_base;  // PC, or rs1 for JALR
                logic [`XLEN-1:0]       imm;
                logic [`XLEN-1:0]       link_val;     // PC+4
                logic [`REG_ADDR_W-1:0] rd;
        } dec_item_t;

        typedef struct packed {
                logic [`REG_ADDR_W-1:0] rd;
                logic [`XLEN-1:0]       data;
        } wb_t;

        typedef struct packed {
                logic [`XLEN-1:0]       pc;
        } redirect_t;

endpackage

`default_nettype wire

//--- rv_decode_stage.sv
/* RV64 decode stage
 * Splits the instruction, builds its immediate and selects the ALU operands
 */

`default_nettype none

`include "rv_exec_config.svh"

module rv_decode_stage (
        input  logic                   clk,
        input  logic                   rst_i,
        input  logic                   valid_i,
        input  rv_exec_pkg::exec_req_t req_i,
        output logic                   dec_valid_o,
        output rv_exec_pkg::dec_item_t dec_o
);

        import rv_exec_pkg::*;

        opcode_e                opcode;
        logic [2:0]             funct3;
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   alt_op;         // SUB or SRA select

        logic [`XLEN-1:0]       imm_i;
        logic [`XLEN-1:0]       imm_b;
        logic [`XLEN-1:0]       imm_u;
        logic [`XLEN-1:0]       imm_j;

        alu_op_e                alu_fn;
        dec_item_t              dec_next;
        logic                   op_known;

        //////////////////////////////////////////////////////////////////////
        // Fields and immediates
        //////////////////////////////////////////////////////////////////////
        assign opcode = opcode_e'(req_i.inst[6:0]);
        assign funct3 = req_i.inst[14:12];
        assign funct7 = req_i.inst[31:25];
        assign rd     = req_i.inst[11:7];

        assign imm_i = {{(`XLEN-12){req_i.inst[31]}}, req_i.inst[31:20]};
        assign imm_b = {{(`XLEN-13){req_i.inst[31]}}, req_i.inst[31], req_i.inst[7],
                        req_i.inst[30:25], req_i.inst[11:8], 1'b0};
        assign imm_u = {{(`XLEN-32){req_i.inst[31]}}, req_i.inst[31:12], 12'b0};
        assign imm_j = {{(`XLEN-21){req_i.inst[31]}}, req_i.inst[31], req_i.inst[19:12],
                        req_i.inst[20], req_i.inst[30:21], 1'b0};

        // ADDI has no subtract form, so bit 30 only matters for OP_REG or shifts
        assign alt_op = funct7[5] & ((opcode == OP_REG) | (funct3 == 3'b101));

        always_comb begin
                case (funct3)
                        3'b000:  alu_fn = alt_op ? ALU_SUB : ALU_ADD;
                        3'b001:  alu_fn = ALU_SLL;
                        3'b010:  alu_fn = ALU_SLT;
                        3'b011:  alu_fn = ALU_SLTU;
                        3'b100:  alu_fn = ALU_XOR;
                        3'b101:  alu_fn = alt_op ? ALU_SRA : ALU_SRL;
                        3'b110:  alu_fn = ALU_OR;
                        default: alu_fn = ALU_AND;
                endcase
        end

        //////////////////////////////////////////////////////////////////////
        // Operand select
        //////////////////////////////////////////////////////////////////////
        always_comb begin
                dec_next.kind        = CTL_ALU;
                dec_next.alu_op      = alu_fn;
                dec_next.br_cond     = br_cond_e'(funct3);
                dec_next.opnd_a      = req_i.rs1_val;
                dec_next.opnd_b      = req_i.rs2_val;
                dec_next.target_base = req_i.pc;
                dec_next.imm         = imm_i;
                dec_next.link_val    = req_i.pc + `XLEN'(4);
                dec_next.rd          = rd;
                op_known             = 1'b1;

                case (opcode)
                        OP_REG: begin
                        end
                        OP_IMM: begin
                                dec_next.opnd_b = imm_i;        // Shamt sits in low bits
                        end
                        OP_LUI: begin
                                dec_next.alu_op = ALU_ADD;
                                dec_next.opnd_a = '0;
                                dec_next.opnd_b = imm_u;
                        end
                        OP_AUIPC: begin
                                dec_next.alu_op = ALU_ADD;
                                dec_next.opnd_a = req_i.pc;
                                dec_next.opnd_b = imm_u;
                        end
                        OP_BRANCH: begin
                                dec_next.kind = CTL_BRANCH;
                                dec_next.imm  = imm_b;
                        end
                        OP_JAL: begin
                                dec_next.kind = CTL_JUMP;
                                dec_next.imm  = imm_j;
                        end
                        OP_JALR: begin
                                dec_next.kind        = CTL_JUMP;
                                dec_next.target_base = req_i.rs1_val;
                        end
                        default: op_known = 1'b0;       // Dropped
                endcase
        end

        //////////////////////////////////////////////////////////////////////
        // Pipeline register
        //////////////////////////////////////////////////////////////////////
        always_ff @(posedge clk) begin
                if (rst_i) begin
                        dec_valid_o <= 1'b0;
                end else begin
                        dec_valid_o <= valid_i & op_known;
                end
        end

        always_ff @(posedge clk) begin
                if (valid_i) begin
                        dec_o <= dec_next;
                end
        end

endmodule

`default_nettype wire

//--- rv_alu_branch_stage.sv
/* RV64 execute stage
 * ALU, branch compare and jump target, with registered write-back and redirect
 */

`default_nettype none

`include "rv_exec_config.svh"

module rv_alu_branch_stage (
        input  logic                   clk,
        input  logic                   rst_i,
        input  logic                   dec_valid_i,
        input  rv_exec_pkg::dec_item_t dec_i,
        output logic                   wb_valid_o,
        output rv_exec_pkg::wb_t       wb_o,
        output logic                   redir_valid_o,
        output rv_exec_pkg::redirect_t redir_o
);

        import rv_exec_pkg::*;

        logic [5:0]       shamt;
        logic             eq;
        logic             lt_s;
        logic             lt_u;
        logic             br_taken;
        logic [`XLEN-1:0] alu_res;
        logic [`XLEN-1:0] taken_tgt;
        logic [`XLEN-1:0] seq_tgt;
        wb_t              wb_next;
        redirect_t        redir_next;
        logic             has_wb;
        logic             has_redir;

        //////////////////////////////////////////////////////////////////////
        // Compare and ALU
        //////////////////////////////////////////////////////////////////////
        assign shamt = dec_i.opnd_b[5:0];
        assign eq    = (dec_i.opnd_a == dec_i.opnd_b);
        assign lt_s  = ($signed(dec_i.opnd_a) < $signed(dec_i.opnd_b));
        assign lt_u  = (dec_i.opnd_a < dec_i.opnd_b);

        always_comb begin
                case (dec_i.alu_op)
                        ALU_ADD:  alu_res = dec_i.opnd_a + dec_i.opnd_b;
                        ALU_SUB:  alu_res = dec_i.opnd_a - dec_i.opnd_b;
                        ALU_SLL:  alu_res = dec_i.opnd_a << shamt;
                        ALU_SLT:  alu_res = {{(`XLEN-1){1'b0}}, lt_s};
                        ALU_SLTU: alu_res = {{(`XLEN-1){1'b0}}, lt_u};
                        ALU_XOR:  alu_res = dec_i.opnd_a ^ dec_i.opnd_b;
                        ALU_SRL:  alu_res = dec_i.opnd_a >> shamt;
                        ALU_SRA:  alu_res = $signed(dec_i.opnd_a) >>> shamt;
                        ALU_OR:   alu_res = dec_i.opnd_a | dec_i.opnd_b;
                        ALU_AND:  alu_res = dec_i.opnd_a & dec_i.opnd_b;
                        default:  alu_res = '0;
                endcase
        end

        always_comb begin
                case (dec_i.br_cond)
                        BR_BEQ:  br_taken = eq;
                        BR_BNE:  br_taken = ~eq;
                        BR_BLT:  br_taken = lt_s;
                        BR_BGE:  br_taken = ~lt_s;
                        BR_BLTU: br_taken = lt_u;
                        BR_BGEU: br_taken = ~lt_u;
                        default: br_taken = 1'b0;       // Reserved funct3 falls through
                endcase
        end

        //////////////////////////////////////////////////////////////////////
        // Result select
        //////////////////////////////////////////////////////////////////////
        assign taken_tgt = dec_i.target_base + dec_i.imm;
        assign seq_tgt   = dec_i.target_base + `XLEN'(4);

        always_comb begin
                wb_next.rd = dec_i.rd;
                if (dec_i.kind == CTL_JUMP) begin
                        wb_next.data   = dec_i.link_val;
                        redir_next.pc  = {taken_tgt[`XLEN-1:1], 1'b0};  // JALR clears bit 0
                end else begin
                        wb_next.data   = alu_res;
                        redir_next.pc  = br_taken ? taken_tgt : seq_tgt;
                end
        end

        assign has_wb    = (dec_i.kind == CTL_ALU) | (dec_i.kind == CTL_JUMP);
        assign has_redir = (dec_i.kind == CTL_BRANCH) | (dec_i.kind == CTL_JUMP);

        always_ff @(posedge clk) begin
                if (rst_i) begin
                        wb_valid_o    <= 1'b0;
                        redir_valid_o <= 1'b0;
                end else begin
                        wb_valid_o    <= dec_valid_i & has_wb;
                        redir_valid_o <= dec_valid_i & has_redir;
                end
        end

        always_ff @(posedge clk) begin
                if (dec_valid_i) begin
                        wb_o    <= wb_next;
                        redir_o <= redir_next;
                end
        end

endmodule

`default_nettype wire

//--- rv_execute_top.sv
/* RV64 integer execute pipeline
 * Decode stage followed by the ALU and branch stage, two cycles in all
 */

`default_nettype none

module rv_execute_top (
        input  logic                   clk,
        input  logic                   rst_i,
        input  logic                   valid_i,
        input  rv_exec_pkg::exec_req_t req_i,
        output logic                   wb_valid_o,
        output rv_exec_pkg::wb_t       wb_o,
        output logic                   redir_valid_o,
        output rv_exec_pkg::redirect_t redir_o
);

        import rv_exec_pkg::*;

        logic      dec_valid;   // Stage 1 strobe
        dec_item_t dec_item;

        rv_decode_stage u_decode (
                .clk         (clk),
                .rst_i       (rst_i),
                .valid_i     (valid_i),
                .req_i       (req_i),
                .dec_valid_o (dec_valid),
                .dec_o       (dec_item)
        );

        rv_alu_branch_stage u_exec (
                .clk           (clk),
                .rst_i         (rst_i),
                .dec_valid_i   (dec_valid),
                .dec_i         (dec_item),
                .wb_valid_o    (wb_valid_o),
                .wb_o          (wb_o),
                .redir_valid_o (redir_valid_o),
                .redir_o       (redir_o)
        );

endmodule

`default_nettype wire

//--- rv_execute_assert.sv
/* Execute pipeline assertions
 * Output valid timing and redirect alignment on the top level
 */

`default_nettype none

module rv_execute_assert (
        input logic                   clk,
        input logic                   rst_i,
        input logic                   valid_i,
        input logic                   wb_valid_o,
        input logic                   redir_valid_o,
        input rv_exec_pkg::redirect_t redir_o
);

        reset_clears_valids: assert property (@(posedge clk)
                rst_i |=> !wb_valid_o && !redir_valid_o)
                else $error("output valid high in the cycle after reset");

        valid_follows_strobe: assert property (@(posedge clk) disable iff (rst_i)
                (wb_valid_o || redir_valid_o) |-> $past(valid_i, 2))
                else $error("output valid without a strobe two cycles earlier");

        redirect_aligned: assert property (@(posedge clk) disable iff (rst_i)
                redir_valid_o |-> !redir_o.pc[0])
                else $error("redirect target has bit 0 set");

endmodule

bind rv_execute_top rv_execute_assert u_assert (
        .clk           (clk),
        .rst_i         (rst_i),
        .valid_i       (valid_i),
        .wb_valid_o    (wb_valid_o),
        .redir_valid_o (redir_valid_o),
        .redir_o       (redir_o)
);

`default_nettype wire

//--- tb_rv_execute.sv
/* Testbench for the RV64 execute pipeline
 * Directed tests with an ISA reference model and a two-cycle expectation pipe
 */

`default_nettype none

`include "rv_exec_config.svh"

module tb_rv_execute;

        import rv_exec_pkg::*;

        // Reset, 40 ALU, 27 immediate, 4 upper, 18 branch, 8 jump, 8 stream, 6 drains
        localparam int TEST_CYCLES = 9 + 40 + 27 + 4 + 18 + 8 + 8 + 6 * 4;
        localparam int MAX_CYCLES  = TEST_CYCLES + 40;
        localparam logic [63:0] MSB = 64'h8000_0000_0000_0000;

        typedef struct packed {
                logic      wb_valid;
                wb_t       wb;
                logic      redir_valid;
                redirect_t redir;
        } expect_t;

        logic      clk;
        logic      rst_i;
        logic      valid_i;
        exec_req_t req_i;
        logic      wb_valid_o;
        wb_t       wb_o;
        logic      redir_valid_o;
        redirect_t redir_o;

        expect_t     nxt;               // Expectation for the strobe being driven
        expect_t     exp_q [0:1];
        logic [31:0] lfsr;
        int          err_value;
        int          err_valid;
        int          cycles;

        rv_execute_top DUT (
                .clk           (clk),
                .rst_i         (rst_i),
                .valid_i       (valid_i),
                .req_i         (req_i),
                .wb_valid_o    (wb_valid_o),
                .wb_o          (wb_o),
                .redir_valid_o (redir_valid_o),
                .redir_o       (redir_o)
        );

        always #4 clk = ~clk;

        //////////////////////////////////////////////////////////////////////
        // Reference model and stimulus helpers
        //////////////////////////////////////////////////////////////////////
        function automatic logic [63:0] rand_bits(input int n);
                logic [63:0] r;
                logic        fb;
                r = '0;
                for (int i = 0; i < n; i++) begin
                        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
                        lfsr = {lfsr[30:0], fb};
                        r    = {r[62:0], fb};
                end
                return r;
        endfunction

        function automatic logic [63:0] rand_pc();
                logic [63:0] v;
                v = rand_bits(62);
                return {v[61:0], 2'b00};        // Word aligned
        endfunction

        function automatic logic [63:0] ref_alu(input logic [2:0] f3, input logic alt,
                                                input logic [63:0] a, input logic [63:0] b);
                case (f3)
                        3'd0: return alt ? a - b : a + b;
                        3'd1: return a << b[5:0];
                        3'd2: return {63'b0, $signed(a) < $signed(b)};
                        3'd3: return {63'b0, a < b};
                        3'd4: return a ^ b;
                        3'd5: begin
                                if (alt) return $signed(a) >>> b[5:0];
                                return a >> b[5:0];
                        end
                        3'd6: return a | b;
                        default: return a & b;
                endcase
        endfunction

        function automatic logic ref_taken(input logic [2:0] f3, input logic [63:0] a,
                                           input logic [63:0] b);
                case (f3)
                        3'd0: return a == b;
                        3'd1: return a != b;
                        3'd4: return $signed(a) < $signed(b);
                        3'd5: return $signed(a) >= $signed(b);
                        3'd6: return a < b;
                        default: return a >= b;
                endcase
        endfunction

        task automatic idle(input int n);
                repeat (n) begin
                        @(posedge clk);
                        #1;
                end
        endtask

        task automatic send(input exec_req_t req, input expect_t e);
                valid_i = 1'b1;
                req_i   = req;
                nxt     = e;
                @(posedge clk);
                #1;
                valid_i = 1'b0;
                nxt     = '0;
        endtask

        task automatic issue_reg(input logic [2:0] f3, input logic alt,
                                 input logic [63:0] a, input logic [63:0] b);
                exec_req_t  r;
                expect_t    e;
                logic [4:0] rd;
                rd = 5'(rand_bits(5));
                r  = '{pc: rand_pc(), inst: {1'b0, alt, 5'd0, 5'd2, 5'd1, f3, rd, OP_REG},
                       rs1_val: a, rs2_val: b};
                e  = '0;
                e.wb_valid = 1'b1;
                e.wb       = '{rd: rd, data: ref_alu(f3, alt, a, b)};
                send(r, e);
        endtask

        task automatic issue_imm(input logic [2:0] f3, input logic [11:0] imm,
                                 input logic [63:0] a);
                exec_req_t  r;
                expect_t    e;
                logic [4:0] rd;
                logic       alt;
                rd  = 5'(rand_bits(5));
                alt = (f3 == 3'd5) & imm[10];   // SRAI funct6
                r   = '{pc: rand_pc(), inst: {imm, 5'd1, f3, rd, OP_IMM},
                        rs1_val: a, rs2_val: rand_bits(64)};
                e   = '0;
                e.wb_valid = 1'b1;
                e.wb       = '{rd: rd, data: ref_alu(f3, alt, a, {{52{imm[11]}}, imm})};
                send(r, e);
        endtask

        task automatic issue_upper(input opcode_e op, input logic [19:0] imm);
                exec_req_t   r;
                expect_t     e;
                logic [4:0]  rd;
                logic [63:0] base;
                rd   = 5'(rand_bits(5));
                r    = '{pc: rand_pc(), inst: {imm, rd, op}, rs1_val: rand_bits(64),
                         rs2_val: rand_bits(64)};
                base = (op == OP_AUIPC) ? r.pc : 64'd0;
                e    = '0;
                e.wb_valid = 1'b1;
                e.wb       = '{rd: rd, data: base + {{32{imm[19]}}, imm, 12'b0}};
                send(r, e);
        endtask

        task automatic issue_branch(input logic [2:0] f3, input logic [63:0] a,
                                    input logic [63:0] b);
                exec_req_t   r;
                expect_t     e;
                logic [63:0] v;
                logic [12:0] imm;
                v   = rand_bits(12);
                imm = {v[11:0], 1'b0};
                r   = '{pc: rand_pc(), rs1_val: a, rs2_val: b,
                        inst: {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OP_BRANCH}};
                e   = '0;
                e.redir_valid = 1'b1;
                e.redir.pc    = ref_taken(f3, a, b) ? r.pc + {{51{imm[12]}}, imm} : r.pc + 64'd4;
                send(r, e);
        endtask

        task automatic issue_jal();
                exec_req_t   r;
                expect_t     e;
                logic [63:0] v;
                logic [20:0] imm;
                logic [4:0]  rd;
                v   = rand_bits(20);
                imm = {v[19:0], 1'b0};
                rd  = 5'(rand_bits(5));
                r   = '{pc: rand_pc(), rs1_val: rand_bits(64), rs2_val: rand_bits(64),
                        inst: {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL}};
                e   = '{wb_valid: 1'b1, wb: '{rd: rd, data: r.pc + 64'd4},
                        redir_valid: 1'b1, redir: r.pc + {{43{imm[20]}}, imm}};
                send(r, e);
        endtask

        task automatic issue_jalr(input logic [63:0] a);
                exec_req_t   r;
                expect_t     e;
                logic [11:0] imm;
                logic [4:0]  rd;
                imm = 12'(rand_bits(12));
                rd  = 5'(rand_bits(5));
                r   = '{pc: rand_pc(), inst: {imm, 5'd1, 3'b000, rd, OP_JALR},
                        rs1_val: a, rs2_val: rand_bits(64)};
                e   = '{wb_valid: 1'b1, wb: '{rd: rd, data: r.pc + 64'd4}, redir_valid: 1'b1,
                        redir: (a + {{52{imm[11]}}, imm}) & ~64'h1};
                send(r, e);
        endtask

        task automatic issue_bad();
                exec_req_t r;
                r = '{pc: rand_pc(), inst: {25'(rand_bits(25)), 7'b0000011},
                      rs1_val: rand_bits(64), rs2_val: rand_bits(64)};
                send(r, '0);            // Load opcode, nothing comes out
        endtask

        //////////////////////////////////////////////////////////////////////
        // Checks
        //////////////////////////////////////////////////////////////////////
        task automatic check_wb(input wb_t exp, input wb_t act);
                if (act !== exp) begin
                        $display("Error: wb_o expected %h, got %h", exp, act);
                        err_value++;
                end
        endtask

        task automatic check_redir(input redirect_t exp, input redirect_t act);
                if (act !== exp) begin
                        $display("Error: redir_o expected %h, got %h", exp, act);
                        err_value++;
                end
        endtask

        always @(posedge clk) begin
                exp_q[0] <= nxt;
                exp_q[1] <= exp_q[0];
        end

        always @(negedge clk) begin
                if (!rst_i) begin
                        if (wb_valid_o !== exp_q[1].wb_valid) begin
                                $display("Write-back valid was %b in cycle %0d, expected %b",
                                         wb_valid_o, cycles, exp_q[1].wb_valid);
                                err_valid++;
                        end else if (wb_valid_o) begin
                                check_wb(exp_q[1].wb, wb_o);
                        end
                        if (redir_valid_o !== exp_q[1].redir_valid) begin
                                $display("Redirect valid was %b in cycle %0d, expected %b",
                                         redir_valid_o, cycles, exp_q[1].redir_valid);
                                err_valid++;
                        end else if (redir_valid_o) begin
                                check_redir(exp_q[1].redir, redir_o);
                        end
                end
        end

        always @(posedge clk) begin
                cycles <= cycles + 1;
                if (cycles >= MAX_CYCLES) begin
                        $display("Timeout: tests still running after %0d cycles", cycles);
                        $display(">>> FAIL");
                        $finish;
                end
        end

        //////////////////////////////////////////////////////////////////////
        // Tests
        //////////////////////////////////////////////////////////////////////
        task automatic test_reg_ops();
                logic [63:0] a;
                for (int f3 = 0; f3 < 8; f3++) begin
                        for (int alt = 0; alt < 2; alt++) begin
                                if (alt == 1 && f3 != 0 && f3 != 5) continue;
                                a = rand_bits(64);
                                issue_reg(3'(f3), 1'(alt), a, rand_bits(64));
                                issue_reg(3'(f3), 1'(alt), 64'hffff_ffff_ffff_fff0, 64'h5);
                                issue_reg(3'(f3), 1'(alt), a | MSB, 64'd0);
                                issue_reg(3'(f3), 1'(alt), a | MSB, 64'd63);
                        end
                end
                idle(4);
        endtask

        task automatic test_imm_ops();
                logic [63:0] a;
                logic [11:0] imm;
                for (int f3 = 0; f3 < 8; f3++) begin
                        for (int alt = 0; alt < 2; alt++) begin
                                if (alt == 1 && f3 != 5) continue;
                                a   = rand_bits(64);
                                imm = 12'(rand_bits(12));
                                if (f3 == 1 || f3 == 5) begin
                                        issue_imm(3'(f3), {1'b0, 1'(alt), 4'b0, imm[5:0]}, a);
                                        issue_imm(3'(f3), {1'b0, 1'(alt), 10'd0}, a | MSB);
                                        issue_imm(3'(f3), {1'b0, 1'(alt), 4'b0, 6'd63}, a | MSB);
                                end else begin
                                        issue_imm(3'(f3), imm, a);
                                        issue_imm(3'(f3), imm | 12'h800, a | MSB);
                                        issue_imm(3'(f3), 12'hfff, a);
                                end
                        end
                end
                idle(4);
        endtask

        task automatic test_upper();
                issue_upper(OP_LUI, 20'(rand_bits(20)));
                issue_upper(OP_LUI, 20'h80000 | 20'(rand_bits(20)));
                issue_upper(OP_AUIPC, 20'(rand_bits(20)));
                issue_upper(OP_AUIPC, 20'h80000 | 20'(rand_bits(20)));
                idle(4);
        endtask

        task automatic test_branches();
                logic [63:0] a;
                for (int f3 = 0; f3 < 8; f3++) begin
                        if (f3 == 2 || f3 == 3) continue;
                        a = rand_bits(64) & ~MSB;
                        issue_branch(3'(f3), a, a);
                        issue_branch(3'(f3), a | MSB, a);
                        issue_branch(3'(f3), a, a | MSB);
                end
                idle(4);
        endtask

        task automatic test_jumps();
                repeat (4) begin
                        issue_jal();
                        issue_jalr(rand_bits(64));
                end
                idle(4);
        endtask

        task automatic test_stream();
                issue_reg(3'd0, 1'b0, rand_bits(64), rand_bits(64));
                issue_bad();
                issue_branch(3'd1, rand_bits(64), rand_bits(64));
                issue_jal();
                issue_bad();
                issue_imm(3'd6, 12'(rand_bits(12)), rand_bits(64));
                issue_upper(OP_AUIPC, 20'(rand_bits(20)));
                issue_jalr(rand_bits(64));
                idle(4);
        endtask

        initial begin
                clk       = 1'b0;
                rst_i     = 1'b1;
                valid_i   = 1'b1;           // ADD strobe held through reset is ignored
                req_i     = '0;
                req_i.inst[6:0] = OP_REG;
                nxt       = '0;
                lfsr      = 32'hd0651b8f;
                err_value = 0;
                err_valid = 0;
                cycles    = 0;
                repeat (8) @(posedge clk);
                #1;
                rst_i   = 1'b0;
                valid_i = 1'b0;

                test_reg_ops();
                test_imm_ops();
                test_upper();
                test_branches();
                test_jumps();
                test_stream();

                $display("Errors: %0d wrong values, %0d valid mismatches", err_value, err_valid);
                if (err_value + err_valid == 0) begin
                        $display(">>> PASS");
                end else begin
                        $display(">>> FAIL");
                end
                $finish;
        end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
rv_exec_pkg.sv
rv_decode_stage.sv
rv_alu_branch_stage.sv
rv_execute_top.sv
rv_execute_assert.sv
tb_rv_execute.sv

//--- run.sh
#!/bin/sh
# Build the execute pipeline testbench with Verilator, run it and scan the log

verilator --binary --timing --assert -f flist.f --top-module tb_rv_execute \
        -o tb_rv_execute > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_rv_execute > sim.log 2>&1 || echo ">>> FAIL" >> sim.log
cat sim.log
grep -q ">>> FAIL" sim.log && exit 1 || exit 0
